//--- hdl/gf_pkg.sv
`default_nettype none

package gf_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // lane geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int LANE_W    = 6;
  localparam int NUM_LANES = 6;
  localparam int STATE_W   = NUM_LANES * LANE_W;

  // GF(4) digit, normal basis
  typedef logic [1:0] gf4_t;

  // GF(2^6) as three GF(4) digits, digit k at bits 2k+1:2k
  typedef logic [LANE_W-1:0] gf64_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // GF(4) base operations
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // squaring swaps the two normal basis coordinates
  function automatic gf4_t gf4_square(gf4_t a);
    return {a[0], a[1]};
  endfunction

  function automatic gf4_t gf4_add(gf4_t a, gf4_t b);
    return a ^ b;
  endfunction

  function automatic gf4_t gf4_mul(gf4_t a, gf4_t b);
    logic t;
    t = (a[0] & b[1]) ^ (a[1] & b[0]);
    return {(a[0] & b[0]) ^ t, (a[1] & b[1]) ^ t};
  endfunction

  // a^3 * b, where a^3 is one for any nonzero a
  function automatic gf4_t gf4_cube_scale(gf4_t a, gf4_t b);
    logic t;
    t = a[0] ^ (~a[0] & a[1]);
    return {t & b[1], t & b[0]};
  endfunction

endpackage

`default_nettype wire

//--- hdl/layer_pkg.sv
`default_nettype none

package layer_pkg;

  localparam int TAG_W = 4;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // command interface
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [0:0] {
    OP_SET_KEY = 1'b0,
    OP_SUBST   = 1'b1
  } op_t;

  typedef logic [gf_pkg::STATE_W-1:0] state_t;

  typedef struct packed {
    op_t              op;
    logic [TAG_W-1:0] tag;
    state_t           data;
  } cmd_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // between layer stages
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic                      valid;
    logic [TAG_W-1:0]          tag;
    logic [gf_pkg::LANE_W-1:0] value;
  } lane_in_t;

  typedef struct packed {
    logic                      valid;
    logic [gf_pkg::LANE_W-1:0] value;
  } lane_out_t;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    state_t           state;
  } result_t;

endpackage

`default_nettype wire

//--- hdl/gf64_pow13.sv
`timescale 1ns/1ps
`default_nettype none

module gf64_pow13 (
  input  gf_pkg::gf64_t a,
  output gf_pkg::gf64_t b
);

  import gf_pkg::*;

  // input digits and their squares
  gf4_t x0;
  gf4_t x1;
  gf4_t x2;
  gf4_t sq0;
  gf4_t sq1;
  gf4_t sq2;

  // cube scaled terms
  gf4_t cs01;
  gf4_t cs02;
  gf4_t cs10;
  gf4_t cs12;
  gf4_t cs20;
  gf4_t cs21;

  // square cross products
  gf4_t sp01;
  gf4_t sp02;
  gf4_t sp12;

  // plain cross products and their weighted forms
  gf4_t p12;
  gf4_t p02;
  gf4_t p01;
  gf4_t w0;
  gf4_t w1;
  gf4_t w2;

  gf4_t d0;
  gf4_t d1;
  gf4_t d2;

  assign x0 = a[1:0];
  assign x1 = a[3:2];
  assign x2 = a[5:4];

  assign sq0 = gf4_square(x0);
  assign sq1 = gf4_square(x1);
  assign sq2 = gf4_square(x2);

  assign cs01 = gf4_cube_scale(x0, x1);
  assign cs02 = gf4_cube_scale(x0, x2);
  assign cs10 = gf4_cube_scale(x1, x0);
  assign cs12 = gf4_cube_scale(x1, x2);
  assign cs20 = gf4_cube_scale(x2, x0);
  assign cs21 = gf4_cube_scale(x2, x1);

  assign sp01 = gf4_mul(sq0, sq1);
  assign sp02 = gf4_mul(sq0, sq2);
  assign sp12 = gf4_mul(sq1, sq2);

  assign p12 = gf4_mul(x1, x2);
  assign p02 = gf4_mul(x0, x2);
  assign p01 = gf4_mul(x0, x1);
  assign w0  = gf4_mul(sq0, p12);
  assign w1  = gf4_mul(sq1, p02);
  assign w2  = gf4_mul(sq2, p01);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // output digit accumulation
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign d0 = gf4_add(gf4_add(gf4_add(gf4_add(x0, x1), gf4_add(cs10, cs12)),
                              gf4_add(gf4_add(cs20, sp01), gf4_add(sp02, w0))),
                      w2);

  assign d1 = gf4_add(gf4_add(gf4_add(gf4_add(x1, x2), gf4_add(cs01, cs20)),
                              gf4_add(gf4_add(cs21, sp01), gf4_add(sp12, w0))),
                      w1);

  assign d2 = gf4_add(gf4_add(gf4_add(gf4_add(x0, x2), gf4_add(cs01, cs02)),
                              gf4_add(gf4_add(cs12, sp02), gf4_add(sp12, w1))),
                      w2);

  assign b = {d2, d1, d0};

endmodule

`default_nettype wire

//--- hdl/sbox_lane.sv
`timescale 1ns/1ps
`default_nettype none

module sbox_lane (
  input  logic                 clk,
  input  logic                 reset,
  input  layer_pkg::lane_in_t  lane_in,
  output layer_pkg::lane_out_t lane_out
);

  import gf_pkg::*;

  gf64_t x;
  gf64_t z;
  gf64_t w;
  gf64_t p;
  gf64_t y;
  logic  affine_bit;

  logic  valid_q;
  gf64_t value_q;

  assign x = lane_in.value;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // into the tower basis
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign z[0] = x[0] ^ x[1] ^ x[2] ^ x[5];
  assign z[1] = x[0] ^ x[3];
  assign z[2] = x[0] ^ x[2] ^ x[4] ^ x[5];
  assign z[3] = x[0] ^ x[1];
  assign z[4] = x[0] ^ x[5];
  assign z[5] = x[0] ^ x[4] ^ x[5];

  gf64_pow13 u_pow13 (
    .a (z),
    .b (w)
  );

  // back to the polynomial basis
  assign p[0] = w[2] ^ w[4];
  assign p[1] = w[0] ^ w[1] ^ w[2] ^ w[4];
  assign p[2] = w[0];
  assign p[3] = w[2] ^ w[3] ^ w[4];
  assign p[4] = w[1] ^ w[5];
  assign p[5] = w[1] ^ w[2] ^ w[3] ^ w[4];

  // affine step depends on the raw input
  assign affine_bit = x[2] ^ x[4];
  assign y          = p ^ {LANE_W{affine_bit}};

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= lane_in.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (lane_in.valid) begin
      value_q <= y;
    end
  end

  assign lane_out = '{valid: valid_q, value: value_q};

  a_valid_follows: assert property (
    @(posedge clk) disable iff (reset)
    lane_in.valid |=> lane_out.valid && !$isunknown(lane_out.value)
  ) else $error("sbox_lane: valid input gave no known output value");

endmodule

`default_nettype wire

//--- hdl/key_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module key_mixer (
  input  logic                                            clk,
  input  logic                                            reset,
  input  logic                                            cmd_strobe,
  input  layer_pkg::cmd_t                                 cmd,
  output layer_pkg::lane_in_t [gf_pkg::NUM_LANES-1:0]     lanes,
  output logic                [layer_pkg::TAG_W-1:0]      tag
);

  import gf_pkg::*;
  import layer_pkg::*;

  state_t           key_q;
  state_t           mixed_q;
  logic             valid_q;
  logic [TAG_W-1:0] tag_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // round key
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (reset) begin
      key_q <= '0;
    end else if (cmd_strobe && cmd.op == OP_SET_KEY) begin
      key_q <= cmd.data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= cmd_strobe && (cmd.op == OP_SUBST);
    end
  end

  // key xor, captured only for substitutions
  always_ff @(posedge clk) begin
    if (cmd_strobe && cmd.op == OP_SUBST) begin
      mixed_q <= cmd.data ^ key_q;
      tag_q   <= cmd.tag;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // lane split
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lanes[i].valid = valid_q;
      lanes[i].tag   = tag_q;
      lanes[i].value = mixed_q[i*LANE_W +: LANE_W];
    end
  end

  assign tag = tag_q;

  a_known_op: assert property (
    @(posedge clk) disable iff (reset)
    cmd_strobe |-> !$isunknown(cmd.op) && (cmd.op inside {OP_SET_KEY, OP_SUBST})
  ) else $error("key_mixer: strobed command carries an unknown op");

endmodule

`default_nettype wire

//--- hdl/lane_collector.sv
`timescale 1ns/1ps
`default_nettype none

module lane_collector (
  input  logic                                         clk,
  input  logic                                         reset,
  input  layer_pkg::lane_out_t [gf_pkg::NUM_LANES-1:0] lanes,
  input  logic                 [layer_pkg::TAG_W-1:0]  tag,
  output logic                                         res_strobe,
  output layer_pkg::result_t                           res
);

  import gf_pkg::*;
  import layer_pkg::*;

  logic [NUM_LANES-1:0] lane_valid;
  state_t               lane_state;
  logic [TAG_W-1:0]     tag_q;
  logic                 strobe_q;
  result_t              res_q;

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_valid[i]                   = lanes[i].valid;
      lane_state[i*LANE_W +: LANE_W]  = lanes[i].value;
    end
  end

  // tag rides alongside the lane stage
  always_ff @(posedge clk) begin
    tag_q <= tag;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // result register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (reset) begin
      strobe_q <= 1'b0;
    end else begin
      strobe_q <= lane_valid[0];
    end
  end

  always_ff @(posedge clk) begin
    if (lane_valid[0]) begin
      res_q <= '{tag: tag_q, state: lane_state};
    end
  end

  assign res_strobe = strobe_q;
  assign res        = res_q;

  a_lanes_agree: assert property (
    @(posedge clk) disable iff (reset)
    (lane_valid == '0) || (lane_valid == '1)
  ) else $error("lane_collector: lane valids disagree");

endmodule

`default_nettype wire

//--- hdl/sbox_layer_top.sv
`timescale 1ns/1ps
`default_nettype none

module sbox_layer_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               cmd_strobe,
  input  layer_pkg::cmd_t    cmd,
  output logic               res_strobe,
  output layer_pkg::result_t res
);

  import gf_pkg::*;
  import layer_pkg::*;

  lane_in_t  [NUM_LANES-1:0] lane_in;
  lane_out_t [NUM_LANES-1:0] lane_out;
  logic      [TAG_W-1:0]     mix_tag;

  key_mixer u_mixer (
    .clk        (clk),
    .reset      (reset),
    .cmd_strobe (cmd_strobe),
    .cmd        (cmd),
    .lanes      (lane_in),
    .tag        (mix_tag)
  );

  // one S-box per lane
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    sbox_lane u_lane (
      .clk      (clk),
      .reset    (reset),
      .lane_in  (lane_in[i]),
      .lane_out (lane_out[i])
    );
  end

  lane_collector u_collector (
    .clk        (clk),
    .reset      (reset),
    .lanes      (lane_out),
    .tag        (mix_tag),
    .res_strobe (res_strobe),
    .res        (res)
  );

endmodule

`default_nettype wire

//--- verif/sbox_layer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sbox_layer_tb;

  import gf_pkg::*;
  import layer_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int LATENCY     = 3;
  localparam int LANE_ROUNDS = 12;
  localparam int KEY_ROUNDS  = 12;
  localparam int BURST_LEN   = 8;
  // commands issued over the whole run
  localparam int CMD_COUNT   = 2 + 64 + 2 * LANE_ROUNDS + 4 * KEY_ROUNDS + 2 * BURST_LEN;
  localparam int WATCHDOG_NS = (CMD_COUNT * 8 + 200) * CLK_PERIOD;

  logic    clk;
  logic    reset;
  logic    cmd_strobe;
  cmd_t    cmd;
  logic    res_strobe;
  result_t res;

  time     sent_times[$];
  result_t results[$];

  sbox_layer_top dut0 (
    .clk        (clk),
    .reset      (reset),
    .cmd_strobe (cmd_strobe),
    .cmd        (cmd),
    .res_strobe (res_strobe),
    .res        (res)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog expired before the tests completed");
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic compare_state(input string name, input state_t exp, input state_t act);
    if (exp !== act) begin
      abort_run($sformatf("mismatch in %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic compare_tag(input string name, input logic [TAG_W-1:0] exp,
                             input logic [TAG_W-1:0] act);
    if (exp !== act) begin
      abort_run($sformatf("mismatch in %s: expected tag %h, actual tag %h", name, exp, act));
    end
  endtask

  function automatic state_t rand_state();
    state_t s;
    s[31:0]         = $urandom();
    s[STATE_W-1:32] = 4'($urandom());
    return s;
  endfunction

  task automatic drive_cmd(input op_t op, input logic [TAG_W-1:0] tag, input state_t data);
    @(posedge clk);
    cmd_strobe <= 1'b1;
    cmd        <= '{op: op, tag: tag, data: data};
    if (op == OP_SUBST) begin
      sent_times.push_back($time);
    end
  endtask

  task automatic drive_idle();
    @(posedge clk);
    cmd_strobe <= 1'b0;
  endtask

  task automatic collect_results(input int n);
    int waited;
    waited = 0;
    while (results.size() < n && waited < 2 * LATENCY + n) begin
      @(posedge clk);
      waited++;
    end
    if (results.size() < n) begin
      abort_run("an expected result never arrived");
    end
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (res_strobe !== 1'b0) begin
        abort_run("result strobe was not low while no substitution was pending");
      end
    end
  endtask

  task automatic load_key(input state_t key);
    drive_cmd(OP_SET_KEY, '0, key);
    drive_idle();
  endtask

  task automatic run_subst(input logic [TAG_W-1:0] tag, input state_t data,
                           output result_t r);
    drive_cmd(OP_SUBST, tag, data);
    drive_idle();
    collect_results(1);
    r = results.pop_front();
  endtask

  // result monitor with latency check against the strobe time
  always @(negedge clk) begin
    time t_sent;
    if (!reset && res_strobe) begin
      if (sent_times.size() == 0) begin
        abort_run("result strobe seen with no substitution pending");
      end else begin
        t_sent = sent_times.pop_front();
        if ($time - t_sent != LATENCY * CLK_PERIOD + CLK_PERIOD / 2) begin
          abort_run($sformatf("result latency was not %0d cycles", LATENCY));
        end else begin
          results.push_back(res);
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic idle_after_reset();
    expect_quiet(8);
    load_key('0);
    expect_quiet(8);
  endtask

  task automatic zero_and_latency();
    result_t r;
    run_subst(4'h5, '0, r);
    compare_state("zero state", '0, r.state);
    compare_tag("zero state", 4'h5, r.tag);
  endtask

  task automatic lane_bijection();
    bit               seen[64];
    result_t          r;
    logic [LANE_W-1:0] v;
    for (int i = 0; i < 64; i++) begin
      v = LANE_W'(i);
      run_subst(TAG_W'(i), {NUM_LANES{v}}, r);
      compare_state("bijection", {NUM_LANES{r.state[LANE_W-1:0]}}, r.state);
      if (seen[r.state[LANE_W-1:0]]) begin
        abort_run($sformatf("S-box output for input %0d repeats an earlier output", i));
      end
      seen[r.state[LANE_W-1:0]] = 1'b1;
    end
  endtask

  task automatic lane_independence();
    state_t            d;
    state_t            d2;
    state_t            exp;
    result_t           r0;
    result_t           r1;
    int                lane;
    logic [LANE_W-1:0] flip;
    for (int n = 0; n < LANE_ROUNDS; n++) begin
      d = rand_state();
      run_subst(TAG_W'(n), d, r0);
      lane = $urandom_range(NUM_LANES - 1);
      flip = LANE_W'($urandom_range(63, 1));
      d2   = d;
      d2[lane*LANE_W +: LANE_W] = d[lane*LANE_W +: LANE_W] ^ flip;
      run_subst(TAG_W'(n), d2, r1);
      exp = r0.state;
      exp[lane*LANE_W +: LANE_W] = r1.state[lane*LANE_W +: LANE_W];
      compare_state("lane independence", exp, r1.state);
      if (r1.state[lane*LANE_W +: LANE_W] == r0.state[lane*LANE_W +: LANE_W]) begin
        abort_run("changed lane input left its output unchanged");
      end
    end
  endtask

  task automatic key_mixing();
    state_t           d;
    state_t           k;
    logic [TAG_W-1:0] tag;
    result_t          r_key;
    result_t          r_ref;
    for (int n = 0; n < KEY_ROUNDS; n++) begin
      d   = rand_state();
      k   = rand_state();
      tag = TAG_W'($urandom());
      // key load directly followed by the substitution
      drive_cmd(OP_SET_KEY, '0, k);
      drive_cmd(OP_SUBST, tag, d);
      drive_idle();
      collect_results(1);
      r_key = results.pop_front();
      load_key('0);
      run_subst(tag, d ^ k, r_ref);
      compare_state("key mixing", r_ref.state, r_key.state);
      compare_tag("key mixing", tag, r_key.tag);
    end
  endtask

  task automatic burst_throughput();
    state_t           datas[BURST_LEN];
    logic [TAG_W-1:0] tags[BURST_LEN];
    result_t          refs[BURST_LEN];
    result_t          r;
    for (int j = 0; j < BURST_LEN; j++) begin
      datas[j] = rand_state();
      tags[j]  = TAG_W'($urandom());
      run_subst(tags[j], datas[j], refs[j]);
    end
    for (int j = 0; j < BURST_LEN; j++) begin
      drive_cmd(OP_SUBST, tags[j], datas[j]);
    end
    drive_idle();
    collect_results(BURST_LEN);
    for (int j = 0; j < BURST_LEN; j++) begin
      r = results.pop_front();
      compare_state("burst throughput", refs[j].state, r.state);
      compare_tag("burst throughput", tags[j], r.tag);
    end
  endtask

  initial begin
    void'($urandom(96));
    reset      = 1'b1;
    cmd_strobe = 1'b0;
    cmd        = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    idle_after_reset();
    zero_and_latency();
    lane_bijection();
    lane_independence();
    key_mixing();
    burst_throughput();

    repeat (8) @(posedge clk);
    if (sent_times.size() != 0 || results.size() != 0) begin
      abort_run("results missing or left over at the end of the run");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- sbox_layer.f
hdl/gf_pkg.sv
hdl/layer_pkg.sv
hdl/gf64_pow13.sv
hdl/sbox_lane.sv
hdl/key_mixer.sv
hdl/lane_collector.sv
hdl/sbox_layer_top.sv
verif/sbox_layer_tb.sv

//--- Makefile
TB_TOP  = sbox_layer_tb
RTL_TOP = sbox_layer_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sbox_layer.f --top-module $(RTL_TOP)
	verilator --lint-only --timing --assert -f sbox_layer.f --top-module $(TB_TOP)

obj_dir/sim: sbox_layer.f hdl/*.sv verif/*.sv
	verilator --binary --timing --assert -j 0 -f sbox_layer.f \
	  --top-module $(TB_TOP) -Mdir obj_dir -o sim

sim: obj_dir/sim
	-./obj_dir/sim | tee sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
